/* sources.f */
+incdir+include
design/tcdm_pkg.sv
design/tcdm_bank.sv
design/tcdm_r_user_filter.sv
design/tcdm_mux_ooo.sv
design/tcdm_subsys.sv
verif/tcdm_subsys_chk.sv
verif/tb_tcdm_subsys.sv

/* Makefile */
# Verilator build and run of the tcdm subsystem testbench

VERILATOR ?= verilator
TOP       ?= tb_tcdm_subsys
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= NO ERRORS

.PHONY: sim clean

# the run passes only when the pass line shows up in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* verif/tb_tcdm_subsys.sv */
// ****************************************
// tcdm subsystem testbench
// directed tests against a reference memory and arbiter model
// ****************************************

`default_nettype none

module tb_tcdm_subsys;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned NB_CHAN = tcdm_pkg::DEFAULT_NB_CHAN;
  localparam int unsigned DW      = tcdm_pkg::DEFAULT_DW;
  localparam int unsigned AW      = tcdm_pkg::DEFAULT_AW;
  localparam int unsigned N_WORDS = tcdm_pkg::DEFAULT_N_WORDS;
  localparam int unsigned IW      = tcdm_pkg::id_width(NB_CHAN);
  localparam int unsigned BW      = DW / 8;

  localparam int CLK_PERIOD     = 20;
  localparam int RST_CYCLES     = 10;
  localparam int WORDS_PER_PORT = 4;
  localparam int POOL_SIZE      = NB_CHAN * WORDS_PER_PORT;
  localparam int BE_ROUNDS      = 8;
  localparam int HOLD_CYCLES    = 5;
  localparam int ACC_TIMEOUT    = 20; // cycles a single request may wait
  // cycle budget per test, two cycles per single access
  localparam int WATCHDOG_CYCLES = 2 * (RST_CYCLES + 4 * POOL_SIZE + 4 * BE_ROUNDS
                                        + 4 * NB_CHAN + 16 + HOLD_CYCLES + 16
                                        + 2 * NB_CHAN + 24);
  localparam logic [31:0] SEED  = 32'h53f2cc40;

  logic                                   clk_i = 1'b0;
  logic                                   rst_ni;
  logic                                   clear_i;
  logic                                   priority_force_i;
  logic              [NB_CHAN-1:0][IW-1:0] priority_i;
  logic              [NB_CHAN-1:0]         in_req;
  logic              [NB_CHAN-1:0]         in_gnt;
  logic              [NB_CHAN-1:0][AW-1:0] in_add;
  tcdm_pkg::access_e [NB_CHAN-1:0]         in_wen;
  logic              [NB_CHAN-1:0][DW-1:0] in_data;
  logic              [NB_CHAN-1:0][BW-1:0] in_be;
  logic              [NB_CHAN-1:0]         in_r_valid;
  logic              [NB_CHAN-1:0]         in_r_ready;
  logic              [NB_CHAN-1:0][DW-1:0] in_r_data;

  logic [DW-1:0] ref_mem [N_WORDS]; // mirrors every granted write
  logic [AW-1:0] pool [POOL_SIZE];  // addresses known to hold data
  int unsigned   model_cnt;         // predicted round-robin counter
  logic          rsp_pending;       // a response is owed to rsp_port
  logic [IW-1:0] rsp_port;
  logic          rsp_read;
  logic [DW-1:0] rsp_data;
  int            errors;
  int            checks;

  tcdm_subsys #(
    .NB_CHAN(NB_CHAN), .DW(DW), .AW(AW), .N_WORDS(N_WORDS)
  ) u_tcdm_subsys (
    .clk_i, .rst_ni, .clear_i, .priority_force_i, .priority_i,
    .in_req, .in_gnt, .in_add, .in_wen, .in_data, .in_be,
    .in_r_valid, .in_r_ready, .in_r_data
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  task automatic check_data(input string name, input logic [DW-1:0] exp,
                            input logic [DW-1:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("** Error: %s expected 0x%h got 0x%h at %0t", name, exp, act, $time);
    end
  endtask

  task automatic check_port(input string name, input logic [IW-1:0] exp,
                            input logic [IW-1:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("** Error: %s expected 0x%h got 0x%h at %0t", name, exp, act, $time);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("** Error: %s expected 0x%h got 0x%h at %0t", name, exp, act, $time);
    end
  endtask

  function automatic int unsigned word_of(input logic [AW-1:0] addr);
    return (32'(addr) / BW) % N_WORDS;
  endfunction

  function automatic logic [AW-1:0] rand_addr();
    return AW'(($urandom % N_WORDS) * BW); // word aligned, anywhere in the bank
  endfunction

  function automatic void ref_write(input logic [AW-1:0] addr, input logic [DW-1:0] data,
                                    input logic [BW-1:0] be);
    for (int b = 0; b < BW; b++) begin
      if (be[b])
        ref_mem[word_of(addr)][b*8 +: 8] = data[b*8 +: 8];
    end
  endfunction

  // index of the highest set bit, 0 when none
  function automatic logic [IW-1:0] port_of(input logic [NB_CHAN-1:0] vec);
    port_of = '0;
    for (int k = 0; k < NB_CHAN; k++) begin
      if (vec[k])
        port_of = IW'(k);
    end
  endfunction

  // walk ranks upward, first requester wins, idle falls back to the counter
  function automatic logic [IW-1:0] expect_winner(input logic [NB_CHAN-1:0] req,
                                                  input int unsigned cnt, input logic force_en,
                                                  input logic [NB_CHAN-1:0][IW-1:0] prio);
    logic [IW-1:0] port;
    logic          found;
    expect_winner = IW'(cnt);
    found         = 1'b0;
    for (int unsigned r = 0; r < NB_CHAN; r++) begin
      port = force_en ? prio[r] : IW'((cnt + r) % NB_CHAN);
      if (!found && req[port]) begin
        expect_winner = port;
        found         = 1'b1;
      end
    end
  endfunction

  // called right after the falling edge drive, looks at the cycle before the next rise
  task automatic sample_cycle(output int gport);
    logic          stall;
    logic [IW-1:0] got_w;
    #1;
    gport = -1;
    stall = rsp_pending && !in_r_ready[rsp_port]; // held response blocks grants
    if (rsp_pending) begin
      check_flag("in_r_valid onehot", 1'b1, $onehot(in_r_valid));
      check_port("in_r_valid port", rsp_port, port_of(in_r_valid));
      if (rsp_read)
        check_data("in_r_data", rsp_data, in_r_data[rsp_port]);
      if (in_r_ready[rsp_port])
        rsp_pending = 1'b0;                       // taken at the coming edge
    end else begin
      check_flag("in_r_valid idle", 1'b0, |in_r_valid);
    end
    check_flag("in_gnt any", (|in_req) && !stall, |in_gnt);
    if (|in_gnt) begin
      got_w = port_of(in_gnt);
      check_flag("in_gnt onehot", 1'b1, $onehot(in_gnt));
      check_port("in_gnt port", expect_winner(in_req, model_cnt, priority_force_i, priority_i),
                 got_w);
      gport       = int'(got_w);
      rsp_pending = 1'b1;
      rsp_port    = got_w;
      rsp_read    = (in_wen[got_w] == tcdm_pkg::ACC_READ);
      rsp_data    = ref_mem[word_of(in_add[got_w])];
      if (in_wen[got_w] == tcdm_pkg::ACC_WRITE)
        ref_write(in_add[got_w], in_data[got_w], in_be[got_w]);
      model_cnt = (model_cnt + 1) % NB_CHAN;
    end
    if (clear_i) begin
      model_cnt   = 0;    // clear wins over the step
      rsp_pending = 1'b0;
    end
  endtask

  // one request on one port, waits for the grant then for its response
  task automatic do_access(input int port, input tcdm_pkg::access_e wen,
                           input logic [AW-1:0] addr, input logic [DW-1:0] data,
                           input logic [BW-1:0] be);
    int g;
    int waited;
    @(negedge clk_i);
    in_req[port]  = 1'b1;
    in_wen[port]  = wen;
    in_add[port]  = addr;
    in_data[port] = data;
    in_be[port]   = be;
    sample_cycle(g);
    waited = 0;
    while (g != port && waited < ACC_TIMEOUT) begin
      @(negedge clk_i);
      sample_cycle(g);
      waited++;
    end
    if (g != port) begin
      errors++;
      $display("timeout: port %0d got no grant within %0d cycles", port, ACC_TIMEOUT);
    end
    @(negedge clk_i);
    in_req[port] = 1'b0;
    sample_cycle(g);                              // response shows up here
  endtask

  // masked ports read continuously until n grants were seen
  task automatic contend(input logic [NB_CHAN-1:0] mask, input int n_grants,
                         input logic windows, output int first);
    int                 g;
    int                 got;
    int                 waited;
    logic [NB_CHAN-1:0] seen;
    @(negedge clk_i);
    for (int k = 0; k < NB_CHAN; k++) begin
      if (mask[k]) begin
        in_req[k] = 1'b1;
        in_wen[k] = tcdm_pkg::ACC_READ;
        in_add[k] = pool[k];
      end
    end
    got    = 0;
    waited = 0;
    seen   = '0;
    first  = -1;
    while (got < n_grants && waited < n_grants + ACC_TIMEOUT) begin
      if (waited > 0)
        @(negedge clk_i);
      sample_cycle(g);
      waited++;
      if (g >= 0) begin
        if (first < 0)
          first = g;
        seen[g] = 1'b1;
        got++;
        if (windows && (got % NB_CHAN == 0)) begin
          check_flag("all ports in grant window", 1'b1, &seen);
          seen = '0;
        end
      end
    end
    if (got < n_grants) begin
      errors++;
      $display("timeout: saw %0d of %0d grants under contention", got, n_grants);
    end
    @(negedge clk_i);
    in_req = '0;
    sample_cycle(g);
  endtask

  task automatic test_write_read();
    for (int p = 0; p < NB_CHAN; p++) begin
      for (int i = 0; i < WORDS_PER_PORT; i++) begin
        pool[p*WORDS_PER_PORT + i] = rand_addr();
        do_access(p, tcdm_pkg::ACC_WRITE, pool[p*WORDS_PER_PORT + i], DW'($urandom), '1);
      end
    end
    for (int p = 0; p < NB_CHAN; p++) begin
      for (int i = 0; i < WORDS_PER_PORT; i++)
        do_access(p, tcdm_pkg::ACC_READ, pool[p*WORDS_PER_PORT + i], '0, '1);
    end
  endtask

  task automatic test_byte_enables();
    int            port;
    logic [AW-1:0] addr;
    for (int i = 0; i < BE_ROUNDS; i++) begin
      port = int'($urandom % NB_CHAN);
      addr = pool[$urandom % POOL_SIZE];
      do_access(port, tcdm_pkg::ACC_WRITE, addr, DW'($urandom), BW'($urandom));
      do_access(port, tcdm_pkg::ACC_READ, addr, '0, '1); // merged word back
    end
  endtask

  task automatic test_round_robin();
    int first;
    contend('1, 3 * NB_CHAN, 1'b1, first);
  endtask

  task automatic test_forced_priority();
    int first;
    @(negedge clk_i);
    priority_force_i = 1'b1;
    priority_i[0]    = IW'(2); // rank 0
    priority_i[1]    = IW'(0);
    priority_i[2]    = IW'(3);
    priority_i[3]    = IW'(1);
    contend('1, NB_CHAN, 1'b0, first);
    check_port("forced rank 0 winner", IW'(2), IW'(first));
    contend(4'b1011, 3, 1'b0, first);              // rank 0 port stays away
    check_port("forced rank 1 winner", IW'(0), IW'(first));
    @(negedge clk_i);
    priority_force_i = 1'b0;
  endtask

  task automatic test_backpressure();
    int                 g;
    int                 waited;
    logic [NB_CHAN-1:0] left;
    @(negedge clk_i);
    in_r_ready[1] = 1'b0;
    in_req[1]     = 1'b1;
    in_wen[1]     = tcdm_pkg::ACC_READ;
    in_add[1]     = pool[1];
    sample_cycle(g);
    check_port("stalled reader grant", IW'(1), IW'(g));
    @(negedge clk_i);
    in_req[1] = 1'b0;
    left      = '1;
    left[1]   = 1'b0;
    for (int k = 0; k < NB_CHAN; k++) begin
      if (left[k]) begin
        in_req[k] = 1'b1;
        in_wen[k] = tcdm_pkg::ACC_READ;
        in_add[k] = pool[k];
      end
    end
    for (int c = 0; c < HOLD_CYCLES; c++) begin
      if (c > 0)
        @(negedge clk_i);
      sample_cycle(g);                            // also checks data is unchanged
      check_flag("in_r_valid[1] held", 1'b1, in_r_valid[1]);
      check_flag("in_gnt while held", 1'b0, |in_gnt);
    end
    @(negedge clk_i);
    in_r_ready[1] = 1'b1;                         // accept, others may go this cycle
    waited = 0;
    while (left != '0 && waited < ACC_TIMEOUT) begin
      if (waited > 0) begin
        @(negedge clk_i);
        in_req = in_req & left;                   // granted ports step back
      end
      sample_cycle(g);
      waited++;
      if (g >= 0)
        left[g] = 1'b0;
    end
    if (left != '0) begin
      errors++;
      $display("timeout: waiting ports were not all granted after the stall");
    end
    @(negedge clk_i);
    in_req = '0;
    sample_cycle(g);
  endtask

  task automatic test_clear();
    int g;
    int first;
    contend('1, 1, 1'b0, first);
    while (model_cnt == 0)
      contend(4'b0001, 1, 1'b0, first);           // get the counter off zero
    @(negedge clk_i);
    clear_i = 1'b1;
    sample_cycle(g);
    @(negedge clk_i);
    clear_i = 1'b0;
    contend('1, NB_CHAN, 1'b1, first);
    check_port("first grant after clear", IW'(0), IW'(first));
  endtask

  initial begin
    int g;
    void'($urandom(SEED));
    errors           = 0;
    checks           = 0;
    model_cnt        = 0;
    rsp_pending      = 1'b0;
    rsp_port         = '0;
    rsp_read         = 1'b0;
    rsp_data         = '0;
    rst_ni           = 1'b0;
    clear_i          = 1'b0;
    priority_force_i = 1'b0;
    priority_i       = '0;
    in_req           = '0;
    in_add           = '0;
    in_data          = '0;
    in_be            = '0;
    in_r_ready       = '1;
    for (int k = 0; k < NB_CHAN; k++)
      in_wen[k] = tcdm_pkg::ACC_READ;
    repeat (RST_CYCLES) @(negedge clk_i);
    check_flag("in_r_valid in reset", 1'b0, |in_r_valid);
    rst_ni = 1'b1;
    @(negedge clk_i);
    sample_cycle(g);
    test_write_read();
    test_byte_enables();
    test_round_robin();
    test_forced_priority();
    test_backpressure();
    test_clear();
    @(negedge clk_i);
    $display("%0d errors in %0d checks", errors, checks);
    if (errors == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired after %0d cycles before the tests finished", WATCHDOG_CYCLES);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

`default_nettype wire

/* verif/tcdm_subsys_chk.sv */
// ****************************************
// tcdm subsystem handshake checker
// bound to the top level initiator ports
// ****************************************

`default_nettype none

module tcdm_subsys_chk #(
  parameter int unsigned NB_CHAN = tcdm_pkg::DEFAULT_NB_CHAN,
  parameter int unsigned DW      = tcdm_pkg::DEFAULT_DW
) (
  input logic                       clk_i,
  input logic                       rst_ni,
  input logic                       clear_i,
  input logic [NB_CHAN-1:0]         in_req,
  input logic [NB_CHAN-1:0]         in_gnt,
  input logic [NB_CHAN-1:0]         in_r_valid,
  input logic [NB_CHAN-1:0]         in_r_ready,
  input logic [NB_CHAN-1:0][DW-1:0] in_r_data
);

  timeunit 1ns;
  timeprecision 1ps;

  a_one_gnt: assert property (@(posedge clk_i) disable iff (!rst_ni) $onehot0(in_gnt))
    else $error("more than one port granted");

  // no grant without a request behind it
  a_gnt_req: assert property (@(posedge clk_i) disable iff (!rst_ni) (in_gnt & ~in_req) == '0)
    else $error("grant on a port that is not requesting");

  a_one_rvalid: assert property (@(posedge clk_i) disable iff (!rst_ni) $onehot0(in_r_valid))
    else $error("response valid on more than one port");

  for (genvar k = 0; k < NB_CHAN; k++) begin : g_port
    // stalled response keeps valid and data
    a_rsp_hold: assert property (@(posedge clk_i) disable iff (!rst_ni || clear_i)
      (in_r_valid[k] && !in_r_ready[k]) |=> (in_r_valid[k] && $stable(in_r_data[k])))
      else $error("held response changed on port %0d", k);

    a_gnt_rsp: assert property (@(posedge clk_i) disable iff (!rst_ni || clear_i)
      in_gnt[k] |=> in_r_valid[k])
      else $error("grant without a response next cycle on port %0d", k);
  end

endmodule

bind tcdm_subsys tcdm_subsys_chk #(.NB_CHAN(NB_CHAN), .DW(DW)) u_chk (
  .clk_i(clk_i), .rst_ni(rst_ni), .clear_i(clear_i),
  .in_req(in_req), .in_gnt(in_gnt), .in_r_valid(in_r_valid),
  .in_r_ready(in_r_ready), .in_r_data(in_r_data)
);

`default_nettype wire

/* design/tcdm_subsys.sv */
// ****************************************
// tcdm scratchpad subsystem
// N initiators share one bank through mux and filter
// ****************************************

`default_nettype none

module tcdm_subsys #(
  parameter int unsigned NB_CHAN = tcdm_pkg::DEFAULT_NB_CHAN,
  parameter int unsigned DW      = tcdm_pkg::DEFAULT_DW,
  parameter int unsigned AW      = tcdm_pkg::DEFAULT_AW,
  parameter int unsigned N_WORDS = tcdm_pkg::DEFAULT_N_WORDS,
  localparam int unsigned IW     = tcdm_pkg::id_width(NB_CHAN),
  localparam int unsigned BW     = DW / 8
) (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  input  logic                                   clear_i,
  input  logic                                   priority_force_i,
  input  logic              [NB_CHAN-1:0][IW-1:0] priority_i,
  input  logic              [NB_CHAN-1:0]         in_req,
  output logic              [NB_CHAN-1:0]         in_gnt,
  input  logic              [NB_CHAN-1:0][AW-1:0] in_add,
  input  tcdm_pkg::access_e [NB_CHAN-1:0]         in_wen,
  input  logic              [NB_CHAN-1:0][DW-1:0] in_data,
  input  logic              [NB_CHAN-1:0][BW-1:0] in_be,
  output logic              [NB_CHAN-1:0]         in_r_valid,
  input  logic              [NB_CHAN-1:0]         in_r_ready,
  output logic              [NB_CHAN-1:0][DW-1:0] in_r_data
);

  // mux <-> filter
  logic              mux_req, mux_gnt, mux_r_valid, mux_r_ready;
  logic [AW-1:0]     mux_add;
  tcdm_pkg::access_e mux_wen;
  logic [DW-1:0]     mux_data, mux_r_data;
  logic [BW-1:0]     mux_be;
  logic [IW-1:0]     mux_user, mux_r_user;
  // filter <-> bank
  logic              mem_req;
  logic [AW-1:0]     mem_add;
  tcdm_pkg::access_e mem_wen;
  logic [DW-1:0]     mem_data, mem_r_data;
  logic [BW-1:0]     mem_be;

  tcdm_mux_ooo #(.NB_CHAN(NB_CHAN), .DW(DW), .AW(AW)) u_mux (
    .clk_i, .rst_ni, .clear_i, .priority_force_i, .priority_i,
    .in_req, .in_gnt, .in_add, .in_wen, .in_data, .in_be,
    .in_r_valid, .in_r_ready, .in_r_data,
    .mux_req, .mux_gnt, .mux_add, .mux_wen, .mux_data, .mux_be, .mux_user,
    .mux_r_valid, .mux_r_ready, .mux_r_data, .mux_r_user
  );

  // sits right at the memory, zero latency boundary
  tcdm_r_user_filter #(.NB_CHAN(NB_CHAN), .DW(DW), .AW(AW)) u_filter (
    .clk_i, .rst_ni, .clear_i,
    .mux_req, .mux_gnt, .mux_add, .mux_wen, .mux_data, .mux_be, .mux_user,
    .mux_r_valid, .mux_r_ready, .mux_r_data, .mux_r_user,
    .mem_req, .mem_add, .mem_wen, .mem_data, .mem_be, .mem_r_data
  );

  tcdm_bank #(.N_WORDS(N_WORDS), .DW(DW), .AW(AW)) u_bank (
    .clk_i, .rst_ni,
    .mem_req, .mem_add, .mem_wen, .mem_data, .mem_be, .mem_r_data
  );

endmodule

`default_nettype wire

/* design/tcdm_mux_ooo.sv */
// ****************************************
// tcdm out-of-order N-to-1 mux
// round-robin or forced arbitration, id-routed responses
// ****************************************

`default_nettype none

`include "tcdm_defs.svh"

module tcdm_mux_ooo #(
  parameter int unsigned NB_CHAN = tcdm_pkg::DEFAULT_NB_CHAN,
  parameter int unsigned DW      = tcdm_pkg::DEFAULT_DW,
  parameter int unsigned AW      = tcdm_pkg::DEFAULT_AW,
  localparam int unsigned IW     = tcdm_pkg::id_width(NB_CHAN),
  localparam int unsigned BW     = DW / 8
) (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  input  logic                                   clear_i,
  // external priority override
  input  logic                                   priority_force_i,
  input  logic              [NB_CHAN-1:0][IW-1:0] priority_i,
  // initiator side
  input  logic              [NB_CHAN-1:0]         in_req,
  output logic              [NB_CHAN-1:0]         in_gnt,
  input  logic              [NB_CHAN-1:0][AW-1:0] in_add,
  input  tcdm_pkg::access_e [NB_CHAN-1:0]         in_wen,
  input  logic              [NB_CHAN-1:0][DW-1:0] in_data,
  input  logic              [NB_CHAN-1:0][BW-1:0] in_be,
  output logic              [NB_CHAN-1:0]         in_r_valid,
  input  logic              [NB_CHAN-1:0]         in_r_ready,
  output logic              [NB_CHAN-1:0][DW-1:0] in_r_data,
  // memory side
  output logic                                   mux_req,
  input  logic                                   mux_gnt,
  output logic                           [AW-1:0] mux_add,
  output tcdm_pkg::access_e                      mux_wen,
  output logic                           [DW-1:0] mux_data,
  output logic                           [BW-1:0] mux_be,
  output logic                           [IW-1:0] mux_user,
  input  logic                                   mux_r_valid,
  output logic                                   mux_r_ready,
  input  logic                           [DW-1:0] mux_r_data,
  input  logic                           [IW-1:0] mux_r_user
);

  logic [IW-1:0]              rr_counter_q; // port holding rank 0 in rr mode
  logic [NB_CHAN-1:0][IW-1:0] rank;         // rank r -> port index
  logic [IW-1:0]              winner;

  // counter steps once per transferred request, wraps at NB_CHAN
  always_ff @(`TCDM_RST_ASYNC) begin
    if (!rst_ni) begin
      rr_counter_q <= '0;
    end else if (clear_i) begin
      rr_counter_q <= '0;              // back to reset order
    end else if (mux_req && mux_gnt) begin
      if (rr_counter_q == IW'(NB_CHAN - 1))
        rr_counter_q <= '0;
      else
        rr_counter_q <= rr_counter_q + 1'b1;
    end
  end

  for (genvar r = 0; r < NB_CHAN; r++) begin : g_rank
    // rotated list unless priority is forced from outside
    assign rank[r] = priority_force_i ? priority_i[r]
                                      : IW'((rr_counter_q + r) % NB_CHAN);
  end

  // winner takes all, lowest ranked requester wins
  // scan from the back so the lowest rank overwrites last
  always_comb begin
    winner = rr_counter_q;             // idle default
    for (int r = NB_CHAN - 1; r >= 0; r--) begin
      if (in_req[rank[r]])
        winner = rank[r];
    end
  end

  // forward the winner's request, tagged with its port index
  assign mux_req  = in_req[winner];
  assign mux_add  = in_add[winner];
  assign mux_wen  = in_wen[winner];
  assign mux_data = in_data[winner];
  assign mux_be   = in_be[winner];
  assign mux_user = winner;

  for (genvar k = 0; k < NB_CHAN; k++) begin : g_port
    assign in_gnt[k]     = (winner == IW'(k)) & in_req[k] & mux_gnt;
    assign in_r_valid[k] = (mux_r_user == IW'(k)) & mux_r_valid; // steer by id
    assign in_r_data[k]  = mux_r_data;                           // shared bus
  end

  // ready comes from whichever port owns the pending response
  assign mux_r_ready = in_r_ready[mux_r_user];

endmodule

`default_nettype wire

/* design/tcdm_r_user_filter.sv */
// ****************************************
// tcdm response user filter
// reflects request id with bank data, stalls on back-pressure
// ****************************************

`default_nettype none

`include "tcdm_defs.svh"

module tcdm_r_user_filter #(
  parameter int unsigned NB_CHAN = tcdm_pkg::DEFAULT_NB_CHAN,
  parameter int unsigned DW      = tcdm_pkg::DEFAULT_DW,
  parameter int unsigned AW      = tcdm_pkg::DEFAULT_AW,
  localparam int unsigned IW     = tcdm_pkg::id_width(NB_CHAN),
  localparam int unsigned BW     = DW / 8
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     clear_i,
  // from the mux
  input  logic                     mux_req,
  output logic                     mux_gnt,
  input  logic              [AW-1:0] mux_add,
  input  tcdm_pkg::access_e        mux_wen,
  input  logic              [DW-1:0] mux_data,
  input  logic              [BW-1:0] mux_be,
  input  logic              [IW-1:0] mux_user,
  output logic                     mux_r_valid,
  input  logic                     mux_r_ready,
  output logic              [DW-1:0] mux_r_data,
  output logic              [IW-1:0] mux_r_user,
  // to the bank
  output logic                     mem_req,
  output logic              [AW-1:0] mem_add,
  output tcdm_pkg::access_e        mem_wen,
  output logic              [DW-1:0] mem_data,
  output logic              [BW-1:0] mem_be,
  input  logic              [DW-1:0] mem_r_data
);

  logic          pending_q; // response sitting at the output
  logic [IW-1:0] id_q;      // id of the granted request
  logic          stall;

  // a waiting response that is not taken this cycle blocks new grants
  assign stall   = pending_q & ~mux_r_ready;
  assign mux_gnt = mux_req & ~stall;

  // zero latency path, bank only sees granted accesses
  assign mem_req  = mux_gnt;
  assign mem_add  = mux_add;
  assign mem_wen  = mux_wen;
  assign mem_data = mux_data;
  assign mem_be   = mux_be;

  always_ff @(`TCDM_RST_ASYNC) begin
    if (!rst_ni) begin
      pending_q <= 1'b0;
      id_q      <= '0;
    end else if (clear_i) begin
      pending_q <= 1'b0;
      id_q      <= '0;
    end else if (mux_gnt) begin
      pending_q <= 1'b1;      // new response next cycle
      id_q      <= mux_user;
    end else if (mux_r_ready) begin
      pending_q <= 1'b0;      // accepted, nothing behind it
    end
  end

  assign mux_r_valid = pending_q;
  assign mux_r_user  = id_q;
  assign mux_r_data  = mem_r_data; // bank holds it until the next read

endmodule

`default_nettype wire

/* design/tcdm_bank.sv */
// ****************************************
// tcdm scratchpad bank
// single port, byte enables, registered read
// ****************************************

`default_nettype none

`include "tcdm_defs.svh"

module tcdm_bank #(
  parameter int unsigned N_WORDS = tcdm_pkg::DEFAULT_N_WORDS,
  parameter int unsigned DW      = tcdm_pkg::DEFAULT_DW,
  parameter int unsigned AW      = tcdm_pkg::DEFAULT_AW,
  localparam int unsigned BW     = DW / 8,
  localparam int unsigned OFFS   = (BW > 1) ? $clog2(BW) : 0,
  localparam int unsigned WAW    = (N_WORDS > 1) ? $clog2(N_WORDS) : 1
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     mem_req,
  input  logic              [AW-1:0] mem_add,
  input  tcdm_pkg::access_e        mem_wen,
  input  logic              [DW-1:0] mem_data,
  input  logic              [BW-1:0] mem_be,
  output logic              [DW-1:0] mem_r_data
);

  logic [DW-1:0]  mem_q [N_WORDS];
  logic [AW-1:0]  word_add;   // byte address in words
  logic [WAW-1:0] idx;
  logic [DW-1:0]  r_data_q;

  assign word_add = mem_add >> OFFS;
  assign idx      = WAW'(word_add % N_WORDS); // wraps past the bank end

  // byte-masked write
  always_ff @(posedge clk_i) begin
    if (mem_req && (mem_wen == tcdm_pkg::ACC_WRITE)) begin
      for (int b = 0; b < BW; b++) begin
        if (mem_be[b])
          mem_q[idx][b*8 +: 8] <= mem_data[b*8 +: 8];
      end
    end
  end

  // read data loads on reads only, holds otherwise
  always_ff @(`TCDM_RST_ASYNC) begin
    if (!rst_ni)
      r_data_q <= '0;
    else if (mem_req && (mem_wen == tcdm_pkg::ACC_READ))
      r_data_q <= mem_q[idx];
  end

  assign mem_r_data = r_data_q;

endmodule

`default_nettype wire

/* design/tcdm_pkg.sv */
// ****************************************
// tcdm package
// default widths, access opcode, id sizing
// ****************************************

`default_nettype none

package tcdm_pkg;

  localparam int unsigned DEFAULT_DW      = 32;  // data bits
  localparam int unsigned DEFAULT_AW      = 16;  // byte address bits
  localparam int unsigned DEFAULT_NB_CHAN = 4;   // initiator ports
  localparam int unsigned DEFAULT_N_WORDS = 256; // bank depth in words

  // wen encoding, low means write
  typedef enum logic {
    ACC_WRITE = 1'b0,
    ACC_READ  = 1'b1
  } access_e;

  // id bits needed to name one of n ports, never below 1
  function automatic int unsigned id_width(input int unsigned n);
    return (n > 1) ? $clog2(n) : 1;
  endfunction

endpackage

`default_nettype wire

/* include/tcdm_defs.svh */
// ****************************************
// tcdm shared macros
// reset sensitivity for the scratchpad RTL
// ****************************************

`ifndef TCDM_DEFS_SVH
`define TCDM_DEFS_SVH

// async active low reset, use as @(`TCDM_RST_ASYNC)
`define TCDM_RST_ASYNC posedge clk_i, negedge rst_ni

`endif
